/* compile.f */
+incdir+source
source/id_remap_pkg.sv
source/ax_issue.sv
source/id_remap_table.sv
source/rsp_restore.sv
source/id_remap_top.sv
verif/id_remap_props.sv
verif/tb_id_remap.sv

/* run.sh */
#!/bin/sh
# Build and run the ID remapper testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_remap -f compile.f \
  -o sim_id_remap > build.log 2>&1 && ./obj_dir/sim_id_remap > sim.log 2>&1 || {
  echo "Build or simulation failed, see build.log and sim.log"
  exit 1
}
grep -q "=== FAIL ===" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation passed"
exit 0

/* source/ax_issue.sv */
/*
  Address channel issue logic
  Admits a request, picks its output ID and pushes it to the remap table,
  then holds the chosen ID stable while the subordinate back-pressures
*/
`default_nettype none
`include "id_remap_defines.svh"

module ax_issue
  import id_remap_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  // Requester side
  input  slv_ax_t slv_ax_i,
  input  logic    slv_valid_i,
  output logic    slv_ready_o,
  // Subordinate side
  output mst_ax_t mst_ax_o,
  output logic    mst_valid_o,
  input  logic    mst_ready_i,
  // Table lookup results
  input  logic    exists_i,
  input  logic    exists_full_i,
  input  out_id_t exists_id_i,
  input  logic    full_i,
  input  out_id_t free_id_i,
  // Table push
  output logic    push_o,
  output out_id_t push_out_id_o
);

  issue_state_e state_q, state_d;
  out_id_t      held_id_q, held_id_d;
  out_id_t      new_id;
  out_id_t      ax_id;
  logic         admit;

  // An in-flight ID needs room in its counter, a new ID needs a free entry
  assign admit  = exists_i ? !exists_full_i : !full_i;
  // Reuse the in-flight output ID so that ordering per input ID is kept
  assign new_id = exists_i ? exists_id_i : free_id_i;

  always_comb begin
    state_d     = state_q;
    held_id_d   = held_id_q;
    mst_valid_o = 1'b0;
    push_o      = 1'b0;
    ax_id       = new_id;
    unique case (state_q)
      ISSUE_READY: begin
        if (slv_valid_i && admit) begin
          // Forward and record the burst in the same cycle
          mst_valid_o = 1'b1;
          push_o      = 1'b1;
          if (!mst_ready_i) begin
            // Freeze the ID since the table has already changed at the next edge
            held_id_d = new_id;
            state_d   = ISSUE_HOLD;
          end
        end
      end
      ISSUE_HOLD: begin
        // Entry is already pushed, only keep presenting the stored ID
        mst_valid_o = 1'b1;
        ax_id       = held_id_q;
        if (mst_ready_i) begin
          state_d = ISSUE_READY;
        end
      end
      default: state_d = ISSUE_READY;
    endcase
  end

  // Requester sees the transfer exactly when the subordinate takes it
  assign slv_ready_o   = mst_valid_o & mst_ready_i;
  assign push_out_id_o = ax_id;
  assign mst_ax_o      = '{id: ax_id, addr: slv_ax_i.addr, len: slv_ax_i.len};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ISSUE_READY;
    end else begin
      state_q <= state_d;
    end
  end

  // Held output ID
  always_ff @(posedge clk_i) begin
    held_id_q <= held_id_d;
  end

endmodule

`default_nettype wire

/* source/id_remap_defines.svh */
/*
  ID remapper parameters
  Widths of the request and response fields and the remap table sizes
*/
`ifndef ID_REMAP_DEFINES_SVH
`define ID_REMAP_DEFINES_SVH

// Input ID width seen on the requester side
`define ID_IN_W    4
// Entries per remap table
`define TABLE_SIZE 4
// Output ID width, which is also the table index width
`define ID_OUT_W   2
// In-flight bursts allowed per table entry
`define MAX_TXNS   3
// Counter width, wide enough for MAX_TXNS
`define CNT_W      2
`define ADDR_W     16
`define LEN_W      4
`define DATA_W     16
`define RESP_W     2

`endif

/* source/id_remap_pkg.sv */
/*
  ID remapper package
  Field types, channel structs and the issue FSM encoding
*/
`default_nettype none
`include "id_remap_defines.svh"

package id_remap_pkg;

  // Field types
  typedef logic [`ID_IN_W-1:0]    in_id_t;
  typedef logic [`ID_OUT_W-1:0]   out_id_t;
  typedef logic [`CNT_W-1:0]      cnt_t;
  typedef logic [`ADDR_W-1:0]     addr_t;
  typedef logic [`LEN_W-1:0]      len_t;
  typedef logic [`DATA_W-1:0]     data_t;
  typedef logic [`RESP_W-1:0]     resp_t;
  // One bit per table entry
  typedef logic [`TABLE_SIZE-1:0] id_field_t;

  // Address channel as seen by the requester
  typedef struct packed {
    in_id_t id;
    addr_t  addr;
    len_t   len;
  } slv_ax_t;

  // Address channel toward the subordinate, with the narrow ID
  typedef struct packed {
    out_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ax_t;

  typedef struct packed {
    in_id_t id;
    resp_t  resp;
  } slv_b_t;

  typedef struct packed {
    out_id_t id;
    resp_t   resp;
  } mst_b_t;

  typedef struct packed {
    in_id_t id;
    data_t  data;
    resp_t  resp;
    logic   last;
  } slv_r_t;

  typedef struct packed {
    out_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

  // Issue FSM of one address channel
  typedef enum logic {
    ISSUE_READY = 1'b0,
    ISSUE_HOLD  = 1'b1
  } issue_state_e;

endpackage

`default_nettype wire

/* source/id_remap_table.sv */
/*
  ID remap table
  Each entry, indexed by output ID, holds an input ID and an in-flight count.
  Provides lowest-free search, input ID lookup, push and pop
*/
`default_nettype none
`include "id_remap_defines.svh"

module id_remap_table
  import id_remap_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  // Push of a newly issued burst
  input  logic    push_i,
  input  in_id_t  push_in_id_i,
  input  out_id_t push_out_id_i,
  // Lookup of the pending request ID
  input  in_id_t  lookup_id_i,
  // Pop on a completed response
  input  logic    pop_i,
  input  out_id_t pop_out_id_i,
  // Search results
  output out_id_t free_id_o,
  output logic    full_o,
  output logic    exists_o,
  output out_id_t exists_id_o,
  output logic    exists_full_o,
  output in_id_t  pop_in_id_o
);

  in_id_t [`TABLE_SIZE-1:0] in_id_q;
  cnt_t   [`TABLE_SIZE-1:0] cnt_q, cnt_d;
  id_field_t                free;
  id_field_t                match;

  // An entry is free when no burst is in flight on it
  always_comb begin
    for (int i = 0; i < `TABLE_SIZE; i++) begin
      free[i]  = (cnt_q[i] == '0);
      // A stale input ID of a free entry must not match
      match[i] = (cnt_q[i] != '0) && (in_id_q[i] == lookup_id_i);
    end
  end

  // Priority search for the lowest free entry, walking down so the lowest wins
  always_comb begin
    free_id_o = '0;
    for (int i = `TABLE_SIZE - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_id_o = out_id_t'(i);
      end
    end
  end

  assign full_o = ~|free;

  // Live input IDs are unique, so at most one bit of match is set
  always_comb begin
    exists_id_o = '0;
    for (int i = `TABLE_SIZE - 1; i >= 0; i--) begin
      if (match[i]) begin
        exists_id_o = out_id_t'(i);
      end
    end
  end

  assign exists_o      = |match;
  assign exists_full_o = (cnt_q[exists_id_o] == cnt_t'(`MAX_TXNS));

  // Original ID of the response that is being popped
  assign pop_in_id_o = in_id_q[pop_out_id_i];

  // Push and pop may hit the same entry in one cycle and then cancel out
  always_comb begin
    cnt_d = cnt_q;
    if (push_i) begin
      cnt_d[push_out_id_i] = cnt_d[push_out_id_i] + 1'b1;
    end
    if (pop_i) begin
      cnt_d[pop_out_id_i] = cnt_d[pop_out_id_i] - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Input IDs are only meaningful while the count is nonzero
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      in_id_q[push_out_id_i] <= push_in_id_i;
    end
  end

endmodule

`default_nettype wire

/* source/id_remap_top.sv */
/*
  ID remapper top level
  Narrows request IDs from the requester to the subordinate and
  restores them on the responses, with one table per direction
*/
`default_nettype none
`include "id_remap_defines.svh"

module id_remap_top
  import id_remap_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  // Requester request channels
  input  slv_ax_t slv_aw_i,
  input  logic    slv_aw_valid_i,
  output logic    slv_aw_ready_o,
  input  slv_ax_t slv_ar_i,
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  // Requester response channels
  output slv_b_t  slv_b_o,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  output slv_r_t  slv_r_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  // Subordinate request channels
  output mst_ax_t mst_aw_o,
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  output mst_ax_t mst_ar_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  // Subordinate response channels
  input  mst_b_t  mst_b_i,
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  input  mst_r_t  mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o
);

  // Write direction table signals
  logic    wr_exists, wr_exists_full, wr_full, wr_push, wr_pop;
  out_id_t wr_exists_id, wr_free_id, wr_push_id, wr_pop_id;
  in_id_t  wr_pop_in_id;
  // Read direction table signals
  logic    rd_exists, rd_exists_full, rd_full, rd_push, rd_pop;
  out_id_t rd_exists_id, rd_free_id, rd_push_id, rd_pop_id;
  in_id_t  rd_pop_in_id;

  ax_issue u_aw_issue (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .slv_ax_i      ( slv_aw_i       ),
    .slv_valid_i   ( slv_aw_valid_i ),
    .slv_ready_o   ( slv_aw_ready_o ),
    .mst_ax_o      ( mst_aw_o       ),
    .mst_valid_o   ( mst_aw_valid_o ),
    .mst_ready_i   ( mst_aw_ready_i ),
    .exists_i      ( wr_exists      ),
    .exists_full_i ( wr_exists_full ),
    .exists_id_i   ( wr_exists_id   ),
    .full_i        ( wr_full        ),
    .free_id_i     ( wr_free_id     ),
    .push_o        ( wr_push        ),
    .push_out_id_o ( wr_push_id     )
  );

  // Lookup and push both use the requester ID held stable on the port
  id_remap_table u_wr_table (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .push_i        ( wr_push        ),
    .push_in_id_i  ( slv_aw_i.id    ),
    .push_out_id_i ( wr_push_id     ),
    .lookup_id_i   ( slv_aw_i.id    ),
    .pop_i         ( wr_pop         ),
    .pop_out_id_i  ( wr_pop_id      ),
    .free_id_o     ( wr_free_id     ),
    .full_o        ( wr_full        ),
    .exists_o      ( wr_exists      ),
    .exists_id_o   ( wr_exists_id   ),
    .exists_full_o ( wr_exists_full ),
    .pop_in_id_o   ( wr_pop_in_id   )
  );

  ax_issue u_ar_issue (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .slv_ax_i      ( slv_ar_i       ),
    .slv_valid_i   ( slv_ar_valid_i ),
    .slv_ready_o   ( slv_ar_ready_o ),
    .mst_ax_o      ( mst_ar_o       ),
    .mst_valid_o   ( mst_ar_valid_o ),
    .mst_ready_i   ( mst_ar_ready_i ),
    .exists_i      ( rd_exists      ),
    .exists_full_i ( rd_exists_full ),
    .exists_id_i   ( rd_exists_id   ),
    .full_i        ( rd_full        ),
    .free_id_i     ( rd_free_id     ),
    .push_o        ( rd_push        ),
    .push_out_id_o ( rd_push_id     )
  );

  id_remap_table u_rd_table (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .push_i        ( rd_push        ),
    .push_in_id_i  ( slv_ar_i.id    ),
    .push_out_id_i ( rd_push_id     ),
    .lookup_id_i   ( slv_ar_i.id    ),
    .pop_i         ( rd_pop         ),
    .pop_out_id_i  ( rd_pop_id      ),
    .free_id_o     ( rd_free_id     ),
    .full_o        ( rd_full        ),
    .exists_o      ( rd_exists      ),
    .exists_id_o   ( rd_exists_id   ),
    .exists_full_o ( rd_exists_full ),
    .pop_in_id_o   ( rd_pop_in_id   )
  );

  // Responses index the tables by their output ID to recover the input ID
  rsp_restore u_rsp_restore (
    .mst_b_i       ( mst_b_i        ),
    .mst_b_valid_i ( mst_b_valid_i  ),
    .mst_b_ready_o ( mst_b_ready_o  ),
    .slv_b_o       ( slv_b_o        ),
    .slv_b_valid_o ( slv_b_valid_o  ),
    .slv_b_ready_i ( slv_b_ready_i  ),
    .mst_r_i       ( mst_r_i        ),
    .mst_r_valid_i ( mst_r_valid_i  ),
    .mst_r_ready_o ( mst_r_ready_o  ),
    .slv_r_o       ( slv_r_o        ),
    .slv_r_valid_o ( slv_r_valid_o  ),
    .slv_r_ready_i ( slv_r_ready_i  ),
    .wr_in_id_i    ( wr_pop_in_id   ),
    .rd_in_id_i    ( rd_pop_in_id   ),
    .wr_pop_o      ( wr_pop         ),
    .wr_pop_id_o   ( wr_pop_id      ),
    .rd_pop_o      ( rd_pop         ),
    .rd_pop_id_o   ( rd_pop_id      )
  );

endmodule

`default_nettype wire

/* source/rsp_restore.sv */
/*
  Response ID restore
  Puts the original input ID back on B and R and pops the remap tables
*/
`default_nettype none
`include "id_remap_defines.svh"

module rsp_restore
  import id_remap_pkg::*;
(
  // Write response
  input  mst_b_t  mst_b_i,
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  output slv_b_t  slv_b_o,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  // Read response
  input  mst_r_t  mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  output slv_r_t  slv_r_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  // Table interface
  input  in_id_t  wr_in_id_i,
  input  in_id_t  rd_in_id_i,
  output logic    wr_pop_o,
  output out_id_t wr_pop_id_o,
  output logic    rd_pop_o,
  output out_id_t rd_pop_id_o
);

  // Each B completes one write burst
  assign slv_b_o       = '{id: wr_in_id_i, resp: mst_b_i.resp};
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;
  assign wr_pop_o      = mst_b_valid_i & slv_b_ready_i;
  assign wr_pop_id_o   = mst_b_i.id;

  // The read entry stays live until the final beat has been taken
  assign slv_r_o       = '{id: rd_in_id_i, data: mst_r_i.data, resp: mst_r_i.resp,
                           last: mst_r_i.last};
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;
  assign rd_pop_o      = mst_r_valid_i & slv_r_ready_i & mst_r_i.last;
  assign rd_pop_id_o   = mst_r_i.id;

endmodule

`default_nettype wire

/* verif/id_remap_props.sv */
/*
  ID remapper properties
  Handshake, hold stability and reset checks on the top level
*/
`default_nettype none

module id_remap_props
  import id_remap_pkg::*;
(
  input wire logic    clk_i,
  input wire logic    rst_ni,
  input wire logic    slv_aw_valid_i,
  input wire logic    slv_aw_ready_o,
  input wire logic    slv_ar_valid_i,
  input wire logic    slv_ar_ready_o,
  input wire mst_ax_t mst_aw_o,
  input wire logic    mst_aw_valid_o,
  input wire logic    mst_aw_ready_i,
  input wire mst_ax_t mst_ar_o,
  input wire logic    mst_ar_valid_o,
  input wire logic    mst_ar_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // A stalled master request keeps its payload and its output ID
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
    else $error("AW master request changed before its transfer");
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
    else $error("AR master request changed before its transfer");

  // The requester transfer and the subordinate transfer coincide
  aw_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_aw_valid_i && slv_aw_ready_o) == (mst_aw_valid_o && mst_aw_ready_i))
    else $error("AW handshakes on both sides differ");
  ar_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_ar_valid_i && slv_ar_ready_o) == (mst_ar_valid_o && mst_ar_ready_i))
    else $error("AR handshakes on both sides differ");

  quiet_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !mst_aw_valid_o && !mst_ar_valid_o && !slv_aw_ready_o && !slv_ar_ready_o)
    else $error("Channel active during reset");

endmodule

bind id_remap_top id_remap_props u_props (.*);

`default_nettype wire

/* verif/tb_id_remap.sv */
/*
  ID remapper testbench
  Random requests and a random subordinate, checked against a model of both tables
*/
`default_nettype none
`include "id_remap_defines.svh"

module tb_id_remap
  import id_remap_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TMO = 4000;

  logic    clk_i, rst_ni;
  slv_ax_t slv_aw_i, slv_ar_i;
  logic    slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  slv_b_t  slv_b_o;
  slv_r_t  slv_r_o;
  logic    slv_b_valid_o, slv_b_ready_i, slv_r_valid_o, slv_r_ready_i;
  mst_ax_t mst_aw_o, mst_ar_o;
  logic    mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;
  mst_b_t  mst_b_i;
  mst_r_t  mst_r_i;
  logic    mst_b_valid_i, mst_b_ready_o, mst_r_valid_i, mst_r_ready_o;

  id_remap_top dut0 (.*);

  always #20 clk_i = ~clk_i;

  logic [15:0] lfsr = 16'd53432;
  int          errors, checks, stalls, holds, issued;
  // Stimulus knobs, probabilities in eighths
  in_id_t      id_mask;
  int          ax_rdy, rsp_rate;
  logic        req_en;
  // Model of both tables, index 0 is the write table
  in_id_t      m_in[2][`TABLE_SIZE];
  int          m_cnt[2][`TABLE_SIZE];
  logic        hold_m[2];
  out_id_t     held_m[2];
  logic        push_v[2];
  out_id_t     push_id[2];
  in_id_t      push_in[2];
  // Subordinate state
  int          b_pend[`TABLE_SIZE];
  len_t        r_q[`TABLE_SIZE][$];
  int          r_rem;

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_ax(input string name, input mst_ax_t got, input mst_ax_t exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_b(input slv_b_t got, input slv_b_t exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail slv_b_o got %h exp %h", got, exp);
    end
  endtask

  task automatic check_r(input slv_r_t got, input slv_r_t exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail slv_r_o got %h exp %h", got, exp);
    end
  endtask

  // Predicts one address channel for the current cycle, xfer marks a transfer
  task automatic issue_step(input int ch, input logic sv, input slv_ax_t req, input logic sr,
                            input logic mv, input mst_ax_t got, input logic mr,
                            output logic xfer);
    mst_ax_t exp;
    logic    ex, admit;
    out_id_t eid;
    xfer = 1'b0;
    ex = 1'b0;
    admit = 1'b0;
    eid = '0;
    exp.addr = req.addr;
    exp.len = req.len;
    if (hold_m[ch]) begin
      exp.id = held_m[ch];
      if (!mv) report_error("master valid dropped under back-pressure");
      else check_ax(ch == 0 ? "mst_aw_o" : "mst_ar_o", got, exp);
      if (mr) begin
        hold_m[ch] = 1'b0;
        xfer = 1'b1;
      end
    end else if (sv) begin
      for (int k = `TABLE_SIZE - 1; k >= 0; k--) begin
        if (m_cnt[ch][k] != 0 && m_in[ch][k] == req.id) begin
          ex = 1'b1;
          eid = out_id_t'(k);
        end
      end
      if (ex) admit = m_cnt[ch][eid] < `MAX_TXNS;
      else begin
        // Lowest entry with nothing in flight
        for (int k = `TABLE_SIZE - 1; k >= 0; k--) begin
          if (m_cnt[ch][k] == 0) begin
            admit = 1'b1;
            eid = out_id_t'(k);
          end
        end
      end
      exp.id = eid;
      if (!admit) begin
        stalls++;
        if (mv) report_error("request forwarded while the table had no room");
      end else begin
        if (!mv) report_error("admitted request was not forwarded");
        else check_ax(ch == 0 ? "mst_aw_o" : "mst_ar_o", got, exp);
        push_v[ch] = 1'b1;
        push_id[ch] = eid;
        push_in[ch] = req.id;
        if (mr) xfer = 1'b1;
        else begin
          hold_m[ch] = 1'b1;
          held_m[ch] = eid;
          holds++;
        end
      end
    end else if (mv) begin
      report_error("master valid raised without a request");
    end
    // The requester is released exactly when the subordinate takes the burst
    check_bit(ch == 0 ? "slv_aw_ready_o" : "slv_ar_ready_o", sr, xfer);
  endtask

  always @(posedge clk_i) begin
    logic   aw_x, ar_x;
    slv_b_t exp_b;
    slv_r_t exp_r;
    int     k, n_new;
    if (rst_ni) begin
      push_v[0] = 1'b0;
      push_v[1] = 1'b0;
      n_new = 0;
      issue_step(0, slv_aw_valid_i, slv_aw_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_o,
                 mst_aw_ready_i, aw_x);
      issue_step(1, slv_ar_valid_i, slv_ar_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_o,
                 mst_ar_ready_i, ar_x);
      // Valid and ready pass straight through the response side
      check_bit("slv_b_valid_o", slv_b_valid_o, mst_b_valid_i);
      check_bit("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i);
      check_bit("slv_r_valid_o", slv_r_valid_o, mst_r_valid_i);
      check_bit("mst_r_ready_o", mst_r_ready_o, slv_r_ready_i);
      // Responses read the model before this cycle's pushes
      if (mst_b_valid_i && slv_b_ready_i) begin
        exp_b.id = m_in[0][mst_b_i.id];
        exp_b.resp = mst_b_i.resp;
        check_b(slv_b_o, exp_b);
        m_cnt[0][mst_b_i.id]--;
      end
      if (mst_r_valid_i && slv_r_ready_i) begin
        exp_r.id = m_in[1][mst_r_i.id];
        exp_r.data = mst_r_i.data;
        exp_r.resp = mst_r_i.resp;
        exp_r.last = mst_r_i.last;
        check_r(slv_r_o, exp_r);
        if (mst_r_i.last) m_cnt[1][mst_r_i.id]--;
      end
      for (int c = 0; c < 2; c++) begin
        if (push_v[c]) begin
          m_cnt[c][push_id[c]]++;
          m_in[c][push_id[c]] = push_in[c];
        end
      end
      // Subordinate stores what it accepted
      if (aw_x) b_pend[mst_aw_o.id]++;
      if (ar_x) r_q[mst_ar_o.id].push_back(mst_ar_o.len);
      // Requester, payload held until the transfer
      if (!slv_aw_valid_i || slv_aw_ready_o) begin
        if (req_en && rand_bits(1) == 1) begin
          slv_aw_i <= '{id: in_id_t'(rand_bits(4)) & id_mask, addr: addr_t'(rand_bits(16)),
                        len: len_t'(rand_bits(4))};
          slv_aw_valid_i <= 1'b1;
          n_new++;
        end else slv_aw_valid_i <= 1'b0;
      end
      if (!slv_ar_valid_i || slv_ar_ready_o) begin
        if (req_en && rand_bits(1) == 1) begin
          slv_ar_i <= '{id: in_id_t'(rand_bits(4)) & id_mask, addr: addr_t'(rand_bits(16)),
                        len: len_t'(rand_bits(2))};
          slv_ar_valid_i <= 1'b1;
          n_new++;
        end else slv_ar_valid_i <= 1'b0;
      end
      issued <= issued + n_new;
      mst_aw_ready_i <= rand_bits(3) < ax_rdy;
      mst_ar_ready_i <= rand_bits(3) < ax_rdy;
      slv_b_ready_i <= rand_bits(3) < 6;
      slv_r_ready_i <= rand_bits(3) < 6;
      // Write responses in order per output ID
      if (!mst_b_valid_i || slv_b_ready_i) begin
        k = rand_bits(2);
        if (rand_bits(3) < rsp_rate && b_pend[k] > 0) begin
          b_pend[k]--;
          mst_b_i <= '{id: out_id_t'(k), resp: resp_t'(rand_bits(2))};
          mst_b_valid_i <= 1'b1;
        end else mst_b_valid_i <= 1'b0;
      end
      // Read bursts of len+1 beats, one burst at a time
      if (!mst_r_valid_i || slv_r_ready_i) begin
        k = rand_bits(2);
        if (mst_r_valid_i && r_rem > 0) begin
          mst_r_i <= '{id: mst_r_i.id, data: data_t'(rand_bits(16)),
                       resp: resp_t'(rand_bits(2)), last: r_rem == 1};
          r_rem--;
        end else if (rand_bits(3) < rsp_rate && r_q[k].size() > 0) begin
          r_rem = int'(r_q[k][0]);
          void'(r_q[k].pop_front());
          mst_r_i <= '{id: out_id_t'(k), data: data_t'(rand_bits(16)),
                       resp: resp_t'(rand_bits(2)), last: r_rem == 0};
          mst_r_valid_i <= 1'b1;
        end else mst_r_valid_i <= 1'b0;
      end
    end
  end

  function automatic logic model_idle();
    logic idle;
    idle = !slv_aw_valid_i && !slv_ar_valid_i && !hold_m[0] && !hold_m[1];
    for (int c = 0; c < 2; c++) begin
      for (int k = 0; k < `TABLE_SIZE; k++) begin
        if (m_cnt[c][k] != 0) idle = 1'b0;
      end
    end
    return idle;
  endfunction

  // Runs n random requests with the given knobs, then drains all bursts
  task automatic run_test(input string name, input in_id_t mask, input int rdy, input int rsp,
                          input int n);
    int t, cyc, err0;
    @(negedge clk_i);
    err0 = errors;
    id_mask = mask;
    ax_rdy = rdy;
    rsp_rate = rsp;
    req_en = 1'b1;
    t = issued + n;
    cyc = 0;
    while (issued < t && cyc < TMO) begin
      @(negedge clk_i);
      cyc++;
    end
    if (issued < t) report_error("requests stopped being accepted");
    req_en = 1'b0;
    ax_rdy = 8;
    rsp_rate = 8;
    t = 0;
    while (!model_idle() && t < TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= TMO) report_error("outstanding bursts did not drain");
    $display("Test %s finished with %0d errors", name, errors - err0);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    slv_aw_i = '0;
    slv_ar_i = '0;
    slv_aw_valid_i = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_b_ready_i = 1'b0;
    slv_r_ready_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_b_i = '0;
    mst_r_i = '0;
    mst_b_valid_i = 1'b0;
    mst_r_valid_i = 1'b0;
    req_en = 1'b0;
    id_mask = '0;
    ax_rdy = 8;
    rsp_rate = 8;
    r_rem = 0;
    for (int c = 0; c < 2; c++) begin
      hold_m[c] = 1'b0;
      for (int k = 0; k < `TABLE_SIZE; k++) begin
        m_cnt[c][k] = 0;
        m_in[c][k] = '0;
      end
    end
    for (int k = 0; k < `TABLE_SIZE; k++) b_pend[k] = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    run_test("distinct_ids", 4'hf, 6, 4, 60);
    run_test("repeated_id", 4'h1, 6, 2, 60);
    run_test("response_restore", 4'h3, 6, 6, 80);
    stalls = 0;
    run_test("full_table", 4'hf, 8, 1, 60);
    if (stalls == 0) report_error("no request was ever stalled on a full table");
    holds = 0;
    run_test("back_pressure", 4'h7, 2, 5, 60);
    if (holds == 0) report_error("no request was ever held under back-pressure");
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
